//--- hw/dhcp_tx_defs.svh
`ifndef DHCP_TX_DEFS_SVH
`define DHCP_TX_DEFS_SVH

`define DHCP_HDR_LEN      240 // bootp fields plus magic cookie
`define DHCP_OPT_SLOT_LEN 8   // code, len, value, pad fill
`define DHCP_OPT_NUM      5
`define DHCP_OPT_TOT_LEN  (`DHCP_OPT_NUM * `DHCP_OPT_SLOT_LEN + 1)
`define DHCP_HOSTNAME     "dhcpcl"
`define DHCP_HOSTNAME_LEN 6
`define DHCP_CLI_PORT     16'd68
`define DHCP_SRV_PORT     16'd67
`define UDP_HDR_LEN       8
`define DHCP_MAGIC_COOKIE 32'h6382_5363

`define CSR_ADDR_W        8
`define CSR_CTRL          8'h00 // bit 0 start, bit 1 busy
`define CSR_XID           8'h04
`define CSR_MAC_HI        8'h08 // upper 16 bits of client mac
`define CSR_MAC_LO        8'h0c
`define CSR_REQ_IP        8'h10
`define CSR_SERVER_ID     8'h14
`define CSR_LEASE         8'h18
`define CSR_MSG_TYPE      8'h1c
`define CSR_OPT_MASK      8'h20
`define CSR_SRC_IP        8'h24
`define CSR_DST_IP        8'h28
`define CSR_IPV4_ID       8'h2c
`endif

//--- hw/dhcp_proto_pkg.sv
`default_nettype none
`include "dhcp_tx_defs.svh"

package dhcp_proto_pkg;

  typedef enum logic [7:0] {
    MSG_DISCOVER = 8'd1,
    MSG_OFFER    = 8'd2,
    MSG_REQUEST  = 8'd3,
    MSG_DECLINE  = 8'd4,
    MSG_ACK      = 8'd5,
    MSG_NAK      = 8'd6,
    MSG_RELEASE  = 8'd7,
    MSG_INFORM   = 8'd8
  } dhcp_msg_type_e;

  typedef enum logic [7:0] {
    OPT_PAD       = 8'd0,
    OPT_HOSTNAME  = 8'd12,
    OPT_REQ_IP    = 8'd50,
    OPT_LEASE     = 8'd51,
    OPT_MSG_TYPE  = 8'd53,
    OPT_SERVER_ID = 8'd54,
    OPT_END       = 8'd255
  } dhcp_opt_code_e;

  //////////////////////////////////////////////////////////////////////
  // options storage
  //////////////////////////////////////////////////////////////////////

  typedef logic [0:`DHCP_OPT_SLOT_LEN-1][7:0] opt_slot_t; // byte 0 is the code
  typedef logic [0:`DHCP_OPT_TOT_LEN-1][7:0]  opt_blk_t;  // byte 0 goes out first

  //////////////////////////////////////////////////////////////////////
  // udp side
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } byte_strm_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;   // udp header plus payload
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [15:0] ipv4_id;
    logic [47:0] dst_mac;
  } udp_meta_t;

endpackage

`default_nettype wire

//--- hw/dhcp_ctrl_pkg.sv
`default_nettype none
`include "dhcp_tx_defs.svh"

package dhcp_ctrl_pkg;
  import dhcp_proto_pkg::*;

  typedef struct packed {
    logic [`CSR_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   bready;
    logic [`CSR_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic [31:0]              xid;
    logic [47:0]              mac;
    logic [31:0]              req_ip;
    logic [31:0]              server_id;
    logic [31:0]              lease;
    dhcp_msg_type_e           msg_type;
    logic [`DHCP_OPT_NUM-1:0] opt_mask; // bit 0 is the first slot
    logic [31:0]              src_ip;
    logic [31:0]              dst_ip;
    logic [15:0]              ipv4_id;
  } dhcp_req_t;

  typedef enum logic [1:0] {OPT_IDLE, OPT_LOAD, OPT_SHIFT, OPT_DONE} opt_state_e;
  typedef enum logic [1:0] {SER_IDLE, SER_READY, SER_STREAM} ser_state_e;

endpackage

`default_nettype wire

//--- hw/dhcp_csr_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_tx_defs.svh"

module dhcp_csr_decode
  import dhcp_proto_pkg::*;
  import dhcp_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      fsm_rst,
  input  axil_req_t axil_req,
  input  logic      frame_done,
  output axil_rsp_t axil_rsp,
  output logic      start_req,
  output dhcp_req_t req
);

  logic aw_rdy, ar_rdy, bvalid, rvalid, busy;
  logic wr_en, rd_en, start;
  logic [31:0] wr_val, rdata;
  logic [31:0] xid, mac_lo, req_ip, server_id, lease, src_ip, dst_ip;
  logic [15:0] mac_hi, ipv4_id;
  dhcp_msg_type_e msg_type;
  logic [`DHCP_OPT_NUM-1:0] opt_mask;

  function automatic logic [31:0] csr_read(input logic [`CSR_ADDR_W-1:0] addr);
    case (addr)
      `CSR_CTRL:      return {30'd0, busy, 1'b0};
      `CSR_XID:       return xid;
      `CSR_MAC_HI:    return {16'd0, mac_hi};
      `CSR_MAC_LO:    return mac_lo;
      `CSR_REQ_IP:    return req_ip;
      `CSR_SERVER_ID: return server_id;
      `CSR_LEASE:     return lease;
      `CSR_MSG_TYPE:  return {24'd0, msg_type};
      `CSR_OPT_MASK:  return {{(32-`DHCP_OPT_NUM){1'b0}}, opt_mask};
      `CSR_SRC_IP:    return src_ip;
      `CSR_DST_IP:    return dst_ip;
      `CSR_IPV4_ID:   return {16'd0, ipv4_id};
      default:        return 32'd0; // unmapped reads zero
    endcase
  endfunction

  function automatic logic [31:0] strb_merge(input logic [31:0] cur, input logic [31:0] dat,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = dat[8*i +: 8];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////////////////////////

  assign wr_en = aw_rdy && axil_req.awvalid && axil_req.wvalid;
  assign start = wr_en && (axil_req.awaddr == `CSR_CTRL) && wr_val[0] && !busy;

  always_comb wr_val = strb_merge(csr_read(axil_req.awaddr), axil_req.wdata, axil_req.wstrb);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      aw_rdy <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      aw_rdy <= !aw_rdy && axil_req.awvalid && axil_req.wvalid && !bvalid; // aw and w together
      if (wr_en) bvalid <= 1'b1;
      else if (axil_req.bready) bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      xid       <= '0;
      mac_hi    <= '0;
      mac_lo    <= '0;
      req_ip    <= '0;
      server_id <= '0;
      lease     <= '0;
      msg_type  <= MSG_DISCOVER;
      opt_mask  <= '0;
      src_ip    <= '0;
      dst_ip    <= '0;
      ipv4_id   <= '0;
    end else if (wr_en) begin
      case (axil_req.awaddr)
        `CSR_XID:       xid       <= wr_val;
        `CSR_MAC_HI:    mac_hi    <= wr_val[15:0];
        `CSR_MAC_LO:    mac_lo    <= wr_val;
        `CSR_REQ_IP:    req_ip    <= wr_val;
        `CSR_SERVER_ID: server_id <= wr_val;
        `CSR_LEASE:     lease     <= wr_val;
        `CSR_MSG_TYPE:  msg_type  <= dhcp_msg_type_e'(wr_val[7:0]);
        `CSR_OPT_MASK:  opt_mask  <= wr_val[`DHCP_OPT_NUM-1:0];
        `CSR_SRC_IP:    src_ip    <= wr_val;
        `CSR_DST_IP:    dst_ip    <= wr_val;
        `CSR_IPV4_ID:   ipv4_id   <= wr_val[15:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      start_req <= 1'b0;
      busy      <= 1'b0;
    end else begin
      start_req <= start;
      if (start) busy <= 1'b1;
      else if (frame_done) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin // snapshot stays put until the next start
      req.xid       <= xid;
      req.mac       <= {mac_hi, mac_lo};
      req.req_ip    <= req_ip;
      req.server_id <= server_id;
      req.lease     <= lease;
      req.msg_type  <= msg_type;
      req.opt_mask  <= opt_mask;
      req.src_ip    <= src_ip;
      req.dst_ip    <= dst_ip;
      req.ipv4_id   <= ipv4_id;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////////////////////////

  assign rd_en = ar_rdy && axil_req.arvalid;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      ar_rdy <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      ar_rdy <= !ar_rdy && axil_req.arvalid && !rvalid;
      if (rd_en) rvalid <= 1'b1;
      else if (axil_req.rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) rdata <= csr_read(axil_req.araddr);
  end

  always_comb begin
    axil_rsp.awready = aw_rdy;
    axil_rsp.wready  = aw_rdy;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = 2'b00; // always okay
    axil_rsp.arready = ar_rdy;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = 2'b00;
  end

endmodule

`default_nettype wire

//--- hw/dhcp_opt_assembler.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_tx_defs.svh"

module dhcp_opt_assembler
  import dhcp_proto_pkg::*;
  import dhcp_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       start_req,
  input  dhcp_req_t  req,
  output logic       opt_done,
  output opt_blk_t   opt_blk,
  output logic [5:0] opt_len,
  output dhcp_req_t  req_hold
);

  localparam logic [8*`DHCP_HOSTNAME_LEN-1:0] host_name = `DHCP_HOSTNAME;

  opt_state_e state, cur_st;
  opt_slot_t slots [`DHCP_OPT_NUM];
  logic [`DHCP_OPT_NUM-1:0] pres;
  logic [2:0] slot_cnt;

  // the load happens in the start_req cycle itself
  always_comb begin
    cur_st = state;
    if (state == OPT_IDLE && start_req) cur_st = OPT_LOAD;
  end

  assign opt_done = (state == OPT_DONE);

  //////////////////////////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= OPT_IDLE;
      slot_cnt <= '0;
    end else begin
      case (cur_st)
        OPT_LOAD: begin
          state    <= OPT_SHIFT;
          slot_cnt <= '0;
        end
        OPT_SHIFT: begin
          slot_cnt <= slot_cnt + 3'd1;
          if (slot_cnt == 3'(`DHCP_OPT_NUM - 1)) state <= OPT_DONE;
        end
        default: state <= OPT_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // slot load and compaction
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    case (cur_st)
      OPT_LOAD: begin
        req_hold <= req;
        pres     <= req.opt_mask;
        slots[0] <= {OPT_MSG_TYPE, 8'd1, req.msg_type, {5{OPT_PAD}}};
        slots[1] <= {OPT_REQ_IP, 8'd4, req.req_ip, {2{OPT_PAD}}};
        slots[2] <= {OPT_SERVER_ID, 8'd4, req.server_id, {2{OPT_PAD}}};
        slots[3] <= {OPT_LEASE, 8'd4, req.lease, {2{OPT_PAD}}};
        slots[4] <= {OPT_HOSTNAME, 8'(`DHCP_HOSTNAME_LEN), host_name}; // fills the slot
        opt_blk  <= {OPT_END, {(`DHCP_OPT_TOT_LEN-1){OPT_PAD}}};      // empty block
        opt_len  <= 6'd1;
      end
      OPT_SHIFT: begin
        for (int i = 0; i < `DHCP_OPT_NUM - 1; i++) begin
          slots[i] <= slots[i+1];
        end
        pres <= pres >> 1;
        if (pres[0]) begin // append at the current end and move the end marker
          for (int k = 0; k < `DHCP_OPT_SLOT_LEN; k++) begin
            opt_blk[int'(opt_len) - 1 + k] <= slots[0][k];
          end
          opt_blk[int'(opt_len) + `DHCP_OPT_SLOT_LEN - 1] <= OPT_END;
          opt_len <= opt_len + 6'(`DHCP_OPT_SLOT_LEN);
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/dhcp_frame_serializer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_tx_defs.svh"

module dhcp_frame_serializer
  import dhcp_proto_pkg::*;
  import dhcp_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       opt_done,
  input  opt_blk_t   opt_blk,
  input  logic [5:0] opt_len,
  input  dhcp_req_t  req_hold,
  input  logic       udp_req,
  output logic       udp_rdy,
  output udp_meta_t  udp_meta,
  output byte_strm_t udp_strm,
  output logic       frame_done
);

  localparam logic [31:0] magic_cookie = `DHCP_MAGIC_COOKIE;

  ser_state_e state;
  logic [8:0] byte_cnt, last_idx;
  logic [5:0] opt_idx;
  logic [7:0] nxt_byte, strm_dat;
  logic strm_val, strm_sof, strm_eof;

  function automatic logic [7:0] hdr_byte(input logic [8:0] idx, input dhcp_req_t r);
    int i;
    logic [7:0] b;
    i = int'(idx);
    b = 8'h00;
    case (idx) inside
      [9'd0:9'd1]:     b = 8'h01;                          // op request, htype ethernet
      9'd2:            b = 8'd6;                           // hlen
      [9'd4:9'd7]:     b = r.xid[(7 - i) * 8 +: 8];
      9'd10:           b = 8'h80;                          // broadcast flag
      [9'd28:9'd33]:   b = r.mac[(33 - i) * 8 +: 8];       // chaddr
      [9'd236:9'd239]: b = magic_cookie[(239 - i) * 8 +: 8];
      default:         b = 8'h00;
    endcase
    return b;
  endfunction

  assign last_idx = 9'(`DHCP_HDR_LEN) + 9'(opt_len) - 9'd1;
  assign opt_idx  = 6'(byte_cnt - 9'(`DHCP_HDR_LEN));

  always_comb begin
    if (byte_cnt < 9'(`DHCP_HDR_LEN)) nxt_byte = hdr_byte(byte_cnt, req_hold);
    else nxt_byte = opt_blk[opt_idx];
  end

  //////////////////////////////////////////////////////////////////////
  // stream control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state      <= SER_IDLE;
      udp_rdy    <= 1'b0;
      byte_cnt   <= '0;
      strm_val   <= 1'b0;
      strm_sof   <= 1'b0;
      strm_eof   <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      strm_val   <= 1'b0;
      strm_sof   <= 1'b0;
      strm_eof   <= 1'b0;
      frame_done <= strm_eof;
      case (state)
        SER_IDLE: if (opt_done) begin
          state    <= SER_READY;
          udp_rdy  <= 1'b1;
          byte_cnt <= '0;
        end
        SER_READY, SER_STREAM: if (udp_req) begin
          state    <= SER_STREAM;
          strm_val <= 1'b1;
          strm_sof <= (byte_cnt == '0);
          strm_eof <= (byte_cnt == last_idx);
          byte_cnt <= byte_cnt + 9'd1;
          if (byte_cnt == last_idx) begin // rdy drops with eof
            state   <= SER_IDLE;
            udp_rdy <= 1'b0;
          end
        end
        default: state <= SER_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SER_IDLE && opt_done) begin
      udp_meta.src_port <= `DHCP_CLI_PORT;
      udp_meta.dst_port <= `DHCP_SRV_PORT;
      udp_meta.length   <= 16'(`UDP_HDR_LEN + `DHCP_HDR_LEN) + 16'(opt_len);
      udp_meta.src_ip   <= req_hold.src_ip;
      udp_meta.dst_ip   <= req_hold.dst_ip;
      udp_meta.ipv4_id  <= req_hold.ipv4_id;
      udp_meta.dst_mac  <= '1; // broadcast
    end
    if (state != SER_IDLE && udp_req) strm_dat <= nxt_byte;
  end

  assign udp_strm = '{dat: strm_dat, val: strm_val, sof: strm_sof, eof: strm_eof};

endmodule

`default_nettype wire

//--- hw/dhcp_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module dhcp_tx_top
  import dhcp_proto_pkg::*;
  import dhcp_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  axil_req_t  axil_req,
  output axil_rsp_t  axil_rsp,
  output logic       udp_rdy,
  output udp_meta_t  udp_meta,
  input  logic       udp_req,
  output byte_strm_t udp_strm
);

  logic start_req, opt_done, frame_done;
  dhcp_req_t req, req_hold;
  opt_blk_t opt_blk;
  logic [5:0] opt_len;

  dhcp_csr_decode u_decode (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .axil_req   (axil_req),
    .frame_done (frame_done),
    .axil_rsp   (axil_rsp),
    .start_req  (start_req),
    .req        (req)
  );

  dhcp_opt_assembler u_opt_asm (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .start_req (start_req),
    .req       (req),
    .opt_done  (opt_done),
    .opt_blk   (opt_blk),
    .opt_len   (opt_len),
    .req_hold  (req_hold)
  );

  dhcp_frame_serializer u_serializer (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .opt_done   (opt_done),
    .opt_blk    (opt_blk),
    .opt_len    (opt_len),
    .req_hold   (req_hold),
    .udp_req    (udp_req),
    .udp_rdy    (udp_rdy),
    .udp_meta   (udp_meta),
    .udp_strm   (udp_strm),
    .frame_done (frame_done)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int rst_cycles = 16
) (
  output logic clk,
  output logic fsm_rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial begin
    fsm_rst <= 1'b1;
    repeat (rst_cycles) @(posedge clk);
    fsm_rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/dhcp_tx_properties.sv
`timescale 1ns/1ps
`default_nettype none

module dhcp_tx_properties
  import dhcp_proto_pkg::*;
  import dhcp_ctrl_pkg::*;
(
  input logic       clk,
  input logic       fsm_rst,
  input axil_req_t  axil_req,
  input axil_rsp_t  axil_rsp,
  input logic       udp_rdy,
  input byte_strm_t udp_strm
);

  rdy_low_in_reset: assert property (@(posedge clk) fsm_rst |=> !udp_rdy)
    else $error("udp_rdy high after a reset cycle");

  eof_has_val: assert property (@(posedge clk) disable iff (fsm_rst)
    udp_strm.eof |-> udp_strm.val)
    else $error("eof without val on udp_strm");

  // write response must wait for the master
  bvalid_hold: assert property (@(posedge clk) disable iff (fsm_rst)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

  byte_needs_rdy: assert property (@(posedge clk) disable iff (fsm_rst)
    udp_strm.val |-> $past(udp_rdy))
    else $error("byte presented while udp_rdy was low");

endmodule

bind dhcp_tx_top dhcp_tx_properties u_props (
  .clk      (clk),
  .fsm_rst  (fsm_rst),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .udp_rdy  (udp_rdy),
  .udp_strm (udp_strm)
);

`default_nettype wire

//--- testbench/dhcp_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dhcp_tx_defs.svh"

module dhcp_tx_tb
  import dhcp_proto_pkg::*;
  import dhcp_ctrl_pkg::*;
();

  localparam int max_len     = `DHCP_HDR_LEN + `DHCP_OPT_TOT_LEN;
  localparam int timeout_cyc = 12000;
  localparam logic [8*`DHCP_HOSTNAME_LEN-1:0] host_str = `DHCP_HOSTNAME;
  localparam logic [31:0] cookie = `DHCP_MAGIC_COOKIE;
  localparam logic [7:0] opt_codes [`DHCP_OPT_NUM] =
    '{OPT_MSG_TYPE, OPT_REQ_IP, OPT_SERVER_ID, OPT_LEASE, OPT_HOSTNAME};
  localparam logic [7:0] opt_lens [`DHCP_OPT_NUM] = '{8'd1, 8'd4, 8'd4, 8'd4, 8'd6};

  logic clk, fsm_rst;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic udp_rdy;
  logic udp_req = 1'b0;
  udp_meta_t udp_meta;
  byte_strm_t udp_strm;

  logic [7:0] exp_frame [max_len];
  int exp_len;
  udp_meta_t exp_meta;
  logic exp_active = 1'b0;
  logic req_last = 1'b0;
  int rx_idx = 0;
  int frames_seen = 0;
  int sof_cnt = 0;
  int stall_pct = 0;
  int cyc_cnt = 0;
  int val_errs = 0;
  int proto_errs = 0;
  logic [31:0] fld_seed = 32'd15;
  logic [31:0] stall_seed = 32'd15;

  tb_clk_gen u_clk_gen (
    .clk     (clk),
    .fsm_rst (fsm_rst)
  );

  dhcp_tx_top u_dhcp_tx_top (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .udp_rdy  (udp_rdy),
    .udp_meta (udp_meta),
    .udp_req  (udp_req),
    .udp_strm (udp_strm)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand_word();
    fld_seed = lcg_next(fld_seed);
    return fld_seed;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    assert (exp == act)
      else begin
        $display("Error at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
        val_errs++;
      end
  endtask

  task automatic report_fault(input string msg);
    $display("At %0t ns: %s", $time, msg);
    proto_errs++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [7:0] slot_byte(input dhcp_req_t r, input int s, input int k);
    logic [47:0] val; // value bytes left aligned, zero past the length
    case (s)
      0:       val = {r.msg_type, 40'd0};
      1:       val = {r.req_ip, 16'd0};
      2:       val = {r.server_id, 16'd0};
      3:       val = {r.lease, 16'd0};
      default: val = host_str;
    endcase
    if (k == 0) return opt_codes[s];
    if (k == 1) return opt_lens[s];
    return val[47 - 8*(k-2) -: 8];
  endfunction

  function automatic void build_frame(input dhcp_req_t r);
    int pos;
    for (int i = 0; i < max_len; i++) exp_frame[i] = 8'h00;
    exp_frame[0]  = 8'h01; // op
    exp_frame[1]  = 8'h01; // htype
    exp_frame[2]  = 8'd6;
    exp_frame[10] = 8'h80; // broadcast flag
    for (int i = 0; i < 4; i++) exp_frame[4+i] = r.xid[31-8*i -: 8];
    for (int i = 0; i < 6; i++) exp_frame[28+i] = r.mac[47-8*i -: 8];
    for (int i = 0; i < 4; i++) exp_frame[236+i] = cookie[31-8*i -: 8];
    pos = `DHCP_HDR_LEN;
    for (int s = 0; s < `DHCP_OPT_NUM; s++) begin
      if (r.opt_mask[s]) begin
        for (int k = 0; k < `DHCP_OPT_SLOT_LEN; k++) exp_frame[pos+k] = slot_byte(r, s, k);
        pos += `DHCP_OPT_SLOT_LEN;
      end
    end
    exp_frame[pos] = OPT_END;
    exp_len = pos + 1;
    exp_meta.src_port = `DHCP_CLI_PORT;
    exp_meta.dst_port = `DHCP_SRV_PORT;
    exp_meta.length   = 16'(`UDP_HDR_LEN + exp_len);
    exp_meta.src_ip   = r.src_ip;
    exp_meta.dst_ip   = r.dst_ip;
    exp_meta.ipv4_id  = r.ipv4_id;
    exp_meta.dst_mac  = 48'hffff_ffff_ffff;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // axi4-lite master
  //////////////////////////////////////////////////////////////////////

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hf;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready) @(negedge clk);
    compare_value("axil_rsp.wready", 64'd1, 64'(axil_rsp.wready));
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.bvalid) @(negedge clk);
    compare_value("axil_rsp.bresp", 64'd0, 64'(axil_rsp.bresp));
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    data = axil_rsp.rdata;
    compare_value("axil_rsp.rresp", 64'd0, 64'(axil_rsp.rresp));
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic readback_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    axil_write(addr, data);
    axil_read(addr, rd);
    compare_value($sformatf("csr 0x%02h", addr), 64'(data), 64'(rd));
  endtask

  task automatic wait_idle();
    logic [31:0] rd;
    rd = 32'd2;
    while (rd[1]) axil_read(`CSR_CTRL, rd); // poll busy
  endtask

  task automatic program_fields(input logic [4:0] mask, output dhcp_req_t r);
    logic [31:0] hi;
    hi          = rand_word();
    r.xid       = rand_word();
    r.mac       = {hi[15:0], rand_word()};
    r.req_ip    = rand_word();
    r.server_id = rand_word();
    r.lease     = rand_word();
    r.msg_type  = dhcp_msg_type_e'(8'((rand_word() >> 16) % 8 + 1));
    r.opt_mask  = mask;
    r.src_ip    = rand_word();
    r.dst_ip    = rand_word();
    r.ipv4_id   = hi[31:16];
    readback_reg(`CSR_XID, r.xid);
    readback_reg(`CSR_MAC_HI, {16'd0, r.mac[47:32]});
    readback_reg(`CSR_MAC_LO, r.mac[31:0]);
    readback_reg(`CSR_REQ_IP, r.req_ip);
    readback_reg(`CSR_SERVER_ID, r.server_id);
    readback_reg(`CSR_LEASE, r.lease);
    readback_reg(`CSR_MSG_TYPE, {24'd0, r.msg_type});
    readback_reg(`CSR_OPT_MASK, {27'd0, r.opt_mask});
    readback_reg(`CSR_SRC_IP, r.src_ip);
    readback_reg(`CSR_DST_IP, r.dst_ip);
    readback_reg(`CSR_IPV4_ID, {16'd0, r.ipv4_id});
  endtask

  task automatic send_frame(input dhcp_req_t r, input int pct, input logic retrigger);
    int seen;
    int sofs;
    logic [31:0] rd;
    build_frame(r);
    stall_pct  = pct;
    rx_idx     = 0;
    exp_active = 1'b1;
    seen       = frames_seen;
    sofs       = sof_cnt;
    axil_write(`CSR_CTRL, 32'd1);
    if (retrigger) begin
      axil_read(`CSR_CTRL, rd);
      compare_value("ctrl.busy", 64'd1, 64'(rd[1]));
      axil_write(`CSR_CTRL, 32'd1); // dropped, frame already running
    end
    @(negedge clk);
    while (frames_seen == seen) @(negedge clk);
    wait_idle();
    if (retrigger) begin
      repeat (20) @(negedge clk);
      assert (!udp_rdy && sof_cnt == sofs + 1)
        else report_fault("a start written while busy produced an extra frame");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // udp side
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    stall_seed = lcg_next(stall_seed);
    udp_req <= (int'(stall_seed[30:16]) % 100) >= stall_pct;
  end

  always @(negedge clk) begin
    if (!fsm_rst && udp_strm.val) begin
      if (udp_strm.sof) sof_cnt++;
      assert (req_last) else report_fault("byte presented after a cycle with udp_req low");
      assert (exp_active) else report_fault("byte presented while no frame was expected");
      if (exp_active) begin
        if (rx_idx == 0) begin // meta is stable for the whole frame
          compare_value("udp_meta.src_port", 64'(exp_meta.src_port), 64'(udp_meta.src_port));
          compare_value("udp_meta.dst_port", 64'(exp_meta.dst_port), 64'(udp_meta.dst_port));
          compare_value("udp_meta.length", 64'(exp_meta.length), 64'(udp_meta.length));
          compare_value("udp_meta.src_ip", 64'(exp_meta.src_ip), 64'(udp_meta.src_ip));
          compare_value("udp_meta.dst_ip", 64'(exp_meta.dst_ip), 64'(udp_meta.dst_ip));
          compare_value("udp_meta.ipv4_id", 64'(exp_meta.ipv4_id), 64'(udp_meta.ipv4_id));
          compare_value("udp_meta.dst_mac", 64'(exp_meta.dst_mac), 64'(udp_meta.dst_mac));
        end
        compare_value($sformatf("udp_strm.dat[%0d]", rx_idx), 64'(exp_frame[rx_idx]),
                      64'(udp_strm.dat));
        compare_value("udp_strm.sof", 64'(rx_idx == 0), 64'(udp_strm.sof));
        compare_value("udp_strm.eof", 64'(rx_idx == exp_len - 1), 64'(udp_strm.eof));
        compare_value("udp_rdy", 64'(rx_idx != exp_len - 1), 64'(udp_rdy)); // drops with eof
        rx_idx++;
        if (udp_strm.eof || rx_idx >= exp_len) begin
          exp_active = 1'b0;
          frames_seen++;
        end
      end
    end
    req_last = udp_req; // what the dut samples at the next edge
  end

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= timeout_cyc) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cyc);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    dhcp_req_t r;
    logic [31:0] rd;
    axil_req <= '0;
    @(negedge clk);
    while (fsm_rst) @(negedge clk);

    axil_write(8'h40, 32'hdead_beef); // unmapped
    axil_read(8'h40, rd);
    compare_value("csr 0x40", 64'd0, 64'(rd));

    program_fields(5'h1f, r);
    send_frame(r, 0, 1'b0);
    program_fields(5'(rand_word() >> 27), r);
    send_frame(r, 25, 1'b0);
    program_fields(5'(rand_word() >> 27), r);
    send_frame(r, 50, 1'b1);
    program_fields(5'(rand_word() >> 27), r);
    send_frame(r, 40, 1'b0);
    assert (sof_cnt == 4) else report_fault("frame count differs from the frames started");

    $display("Errors: %0d value, %0d protocol, %0d total",
             val_errs, proto_errs, val_errs + proto_errs);
    if (val_errs + proto_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dhcp_tx.f
+incdir+hw
hw/dhcp_proto_pkg.sv
hw/dhcp_ctrl_pkg.sv
hw/dhcp_csr_decode.sv
hw/dhcp_opt_assembler.sv
hw/dhcp_frame_serializer.sv
hw/dhcp_tx_top.sv
testbench/tb_clk_gen.sv
testbench/dhcp_tx_properties.sv
testbench/dhcp_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dhcp tx testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module dhcp_tx_tb -f dhcp_tx.f -o dhcp_tx_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dhcp_tx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
